// ==== Bender.yml ====
package:
  name: cpu_top

export_include_dirs:
  - common

sources:
  - files:
      - common/cpu_pkg.sv
      - datapath/alu.sv
      - datapath/register_file.sv
      - datapath/datapath.sv
      - control/control_fsm.sv
      - hdl/pc_counter.sv
      - hdl/main_memory.sv
      - hdl/cpu_top.sv
  - target: simulation
    files:
      - dv/tb_cpu_top.sv

// ==== files.f ====
+incdir+common
common/cpu_pkg.sv
datapath/alu.sv
datapath/register_file.sv
datapath/datapath.sv
control/control_fsm.sv
hdl/pc_counter.sv
hdl/main_memory.sv
hdl/cpu_top.sv
dv/tb_cpu_top.sv

// ==== dv/tb_cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int RETIRE_TIMEOUT = 20;
    localparam int MAX_RETIRES    = 200;
    localparam int QUIET_CYCLES   = 40;

    logic  clk;
    logic  rst;
    logic  start;
    logic  load_we;
    word_t load_addr;
    word_t load_data;
    logic  busy;
    logic  halted;
    logic  retire;
    word_t retire_pc;
    word_t alu_result;
    logic  carry_flag;
    logic  sign_flag;
    logic  zero_flag;

    word_t       prog [$];
    word_t       first_trace [$];
    word_t       second_trace [$];
    word_t       model_mem [`CPU_MEM_WORDS];
    word_t       model_regs [`CPU_NREGS];
    word_t       model_pc;
    logic [31:0] lcg_state;
    logic        started;
    int          value_errors;
    int          protocol_errors;
    int          timeouts;

    cpu_top uut (
        .clk(clk), .rst(rst), .start(start), .load_we(load_we),
        .load_addr(load_addr), .load_data(load_data), .busy(busy),
        .halted(halted), .retire(retire), .retire_pc(retire_pc),
        .alu_result(alu_result), .carry_flag(carry_flag),
        .sign_flag(sign_flag), .zero_flag(zero_flag)
    );

    always #4 clk = ~clk;

    // the core stays quiet until the host first starts it.
    assert property (@(posedge clk) disable iff (rst) !started |-> !busy && !retire && !halted)
        else begin
            protocol_errors++;
            $display("core became active before any start pulse");
        end

    // an accepted start makes the core busy on the next edge.
    assert property (@(posedge clk) disable iff (rst) start && !busy |=> busy)
        else begin
            protocol_errors++;
            $display("core did not become busy after a start pulse");
        end

    // busy covers every instruction of a run.
    assert property (@(posedge clk) disable iff (rst) retire |-> busy)
        else begin
            protocol_errors++;
            $display("core retired an instruction while not busy");
        end

    // first retire comes four cycles into a run.
    assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> !retire ##1 !retire ##1 !retire ##1 retire)
        else begin
            protocol_errors++;
            $display("first instruction did not retire in its fourth cycle");
        end

    // a halted core also satisfies the last step.
    assert property (@(posedge clk) disable iff (rst)
        retire |=> !retire ##1 !retire ##1 !retire ##1 (retire || halted))
        else begin
            protocol_errors++;
            $display("retire strobes were not four cycles apart");
        end

    assert property (@(posedge clk) disable iff (rst) halted |-> !busy && !retire)
        else begin
            protocol_errors++;
            $display("core was busy or retiring while halted");
        end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t enc_reg(input logic [5:0] op, input int rs, input int rt,
                                      input int sh, input logic [3:0] fn);
        word_t w;
        w        = '0;
        w[31:26] = op;
        w[25:21] = rs[4:0];
        w[20:16] = rt[4:0];
        w[15:11] = sh[4:0];
        w[3:0]   = fn;
        return w;
    endfunction

    function automatic word_t enc_imm(input logic [5:0] op, input int rs, input int rt,
                                      input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic add_instr(input word_t w);
        prog.push_back(w);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // result and carry as the instruction set defines them.
    task automatic ref_alu(input logic [3:0] fn, input word_t a, input word_t b,
                           output word_t res, output logic carry);
        res   = '0;
        carry = 1'b0;
        case (fn)
            `CPU_FN_ADD: begin
                // an unsigned sum that wrapped produced a carry out.
                res   = a + b;
                carry = (res < a);
            end
            `CPU_FN_SUB: begin
                res   = a - b;
                carry = (a < b);
            end
            `CPU_FN_AND: res = a & b;
            `CPU_FN_OR:  res = a | b;
            `CPU_FN_XOR: res = a ^ b;
            `CPU_FN_SLL: res = a << b[4:0];
            `CPU_FN_SRL: res = a >> b[4:0];
            `CPU_FN_SRA: res = $signed(a) >>> b[4:0];
            default:     res = '0;
        endcase
    endtask

    task automatic write_reg(input int idx, input word_t value);
        if (idx != 0) begin
            model_regs[idx] = value;
        end
    endtask

    task automatic build_program();
        word_t rnd;
        // r1 to r4 get full 32-bit values from two immediates and a shift.
        for (int r = 1; r <= 4; r++) begin
            rnd = lcg_next();
            add_instr(enc_imm(`CPU_OP_ADDI, 0, r, rnd[31:16]));
            add_instr(enc_reg(`CPU_OP_SHI, r, r, 16, `CPU_FN_SLL));
            rnd = lcg_next();
            add_instr(enc_imm(`CPU_OP_ADDI, r, r, rnd[31:16]));
        end
        for (int k = 0; k < 16; k++) begin
            rnd = lcg_next();
            add_instr(enc_reg(`CPU_OP_ALU, 1 + rnd[31:30], 1 + rnd[29:28], 0, k[3:0] & 4'h7));
        end
        add_instr(enc_reg(`CPU_OP_ALU, 4, 4, 0, `CPU_FN_XOR));
        for (int k = 5; k <= 7; k++) begin
            rnd = lcg_next();
            add_instr(enc_reg(`CPU_OP_SHI, 2, 7, rnd[31:27], k[3:0]));
        end
        rnd = lcg_next();
        add_instr(enc_imm(`CPU_OP_ADDI, 3, 8, rnd[31:16]));
        // store r2 at 0x85, load it back into r10, then show it through an add.
        add_instr(enc_imm(`CPU_OP_ADDI, 0, 9, 16'h0080));
        add_instr(enc_imm(`CPU_OP_SW, 9, 2, 16'h0005));
        add_instr(enc_imm(`CPU_OP_LW, 9, 10, 16'h0005));
        add_instr(enc_reg(`CPU_OP_ALU, 10, 0, 0, `CPU_FN_ADD));
        rnd = lcg_next();
        add_instr(enc_imm(`CPU_OP_ADDI, 1, 0, rnd[31:16]));
        add_instr(enc_imm(`CPU_OP_ADDI, 0, 11, rnd[15:0]));
        add_instr(enc_reg(`CPU_OP_ALU, 11, 0, 0, `CPU_FN_ADD));
        add_instr(enc_reg(`CPU_OP_ALU, 0, 3, 0, `CPU_FN_OR));
        // taken branch skips one word, the second one falls through.
        add_instr(enc_imm(`CPU_OP_BEQ, 2, 2, 16'h0001));
        add_instr(enc_imm(`CPU_OP_ADDI, 0, 12, 16'h0bad));
        add_instr(enc_imm(`CPU_OP_BEQ, 0, 9, 16'h0001));
        add_instr(enc_imm(`CPU_OP_ADDI, 0, 12, 16'h0011));
        // call a one-word subroutine that returns through r31.
        add_instr(enc_imm(`CPU_OP_JAL, 0, 0, 16'h0001));
        add_instr(enc_imm(`CPU_OP_BEQ, 0, 0, 16'h0001));
        add_instr(enc_imm(`CPU_OP_JR, 31, 0, 16'h0000));
        add_instr(enc_imm(`CPU_OP_ADDI, 31, 13, 16'h0000));
        add_instr(enc_imm(`CPU_OP_HALT, 0, 0, 16'h0000));
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            #1;
            load_we   = 1'b1;
            load_addr = word_t'(i);
            load_data = prog[i];
            model_mem[i] = prog[i];
        end
        @(posedge clk);
        #1;
        load_we = 1'b0;
    endtask

    task automatic wait_retire(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < RETIRE_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = retire;
        end
        if (!seen) begin
            timeouts++;
            $display("timed out waiting for an instruction to retire");
        end
    endtask

    // executes the word at the model pc and checks the retire outputs.
    task automatic model_retire(input string run_name, output logic is_halt);
        word_t      ir;
        word_t      a;
        word_t      b;
        word_t      imm_ext;
        word_t      exp_res;
        word_t      next_pc;
        logic [5:0] op;
        logic       exp_carry;
        logic       check_alu;
        string      name;
        ir        = model_mem[model_pc % `CPU_MEM_WORDS];
        op        = ir[31:26];
        a         = model_regs[ir[25:21]];
        b         = model_regs[ir[20:16]];
        imm_ext   = {{16{ir[15]}}, ir[15:0]};
        next_pc   = model_pc + 1;
        exp_res   = '0;
        exp_carry = 1'b0;
        check_alu = 1'b1;
        is_halt   = (op == `CPU_OP_HALT);
        name      = $sformatf("%s pc %0d op %0h", run_name, model_pc, op);
        check_value({name, " retire_pc"}, model_pc, retire_pc);
        case (op)
            `CPU_OP_ALU: begin
                ref_alu(ir[3:0], a, b, exp_res, exp_carry);
                write_reg(ir[25:21], exp_res);
            end
            `CPU_OP_ADDI: begin
                ref_alu(`CPU_FN_ADD, a, imm_ext, exp_res, exp_carry);
                write_reg(ir[20:16], exp_res);
            end
            `CPU_OP_SHI: begin
                ref_alu(ir[3:0], a, word_t'(ir[15:11]), exp_res, exp_carry);
                write_reg(ir[20:16], exp_res);
            end
            `CPU_OP_LW: begin
                ref_alu(`CPU_FN_ADD, a, imm_ext, exp_res, exp_carry);
                write_reg(ir[20:16], model_mem[exp_res % `CPU_MEM_WORDS]);
            end
            `CPU_OP_SW: begin
                ref_alu(`CPU_FN_ADD, a, imm_ext, exp_res, exp_carry);
                model_mem[exp_res % `CPU_MEM_WORDS] = b;
            end
            `CPU_OP_BEQ: begin
                ref_alu(`CPU_FN_SUB, a, b, exp_res, exp_carry);
                if (a == b) begin
                    next_pc = model_pc + 1 + imm_ext;
                end
            end
            `CPU_OP_JAL: begin
                check_alu = 1'b0;
                write_reg(`CPU_LINK_REG, model_pc + 1);
                next_pc = model_pc + 1 + imm_ext;
            end
            `CPU_OP_JR: begin
                check_alu = 1'b0;
                next_pc   = a;
            end
            default: check_alu = 1'b0;
        endcase
        if (check_alu) begin
            check_value({name, " alu_result"}, exp_res, alu_result);
            check_value({name, " carry"}, word_t'(exp_carry), word_t'(carry_flag));
            check_value({name, " sign"}, word_t'(exp_res[31]), word_t'(sign_flag));
            check_value({name, " zero"}, word_t'(exp_res == '0), word_t'(zero_flag));
        end
        model_pc = next_pc;
    endtask

    task automatic run_program(input string run_name, input int pass);
        logic seen;
        logic done;
        int   count;
        int   n;
        @(posedge clk);
        #1;
        start   = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #1;
        start    = 1'b0;
        model_pc = '0;
        done     = 1'b0;
        seen     = 1'b1;
        count    = 0;
        while (seen && !done && count < MAX_RETIRES) begin
            wait_retire(seen);
            if (seen) begin
                if (pass == 0) begin
                    first_trace.push_back(retire_pc);
                end else begin
                    second_trace.push_back(retire_pc);
                end
                model_retire(run_name, done);
                count++;
            end
        end
        if (seen && !done) begin
            timeouts++;
            $display("program never reached its halt instruction");
        end
        n = 0;
        while (!halted && n < RETIRE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            timeouts++;
            $display("halted did not rise after the halt instruction");
        end
        for (n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            assert (halted && !busy && !retire)
            else begin
                protocol_errors++;
                $display("core did not stay halted after the halt instruction");
            end
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        start           = 1'b0;
        load_we         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        started         = 1'b0;
        lcg_state       = 32'h7399;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        build_program();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        load_program();
        repeat (8) @(posedge clk);
        run_program("first run", 0);
        // registers and memory carry over, the program rebuilds its own state.
        run_program("second run", 1);
        check_value("rerun retire count", word_t'(first_trace.size()),
                    word_t'(second_trace.size()));
        foreach (first_trace[i]) begin
            if (i < second_trace.size()) begin
                check_value($sformatf("rerun retire %0d pc", i), first_trace[i],
                            second_trace[i]);
            end
        end
        $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           load_we,
    input  cpu_pkg::word_t load_addr,
    input  cpu_pkg::word_t load_data,
    output logic           busy,
    output logic           halted,
    output logic           retire,
    output cpu_pkg::word_t retire_pc,
    output cpu_pkg::word_t alu_result,
    output logic           carry_flag,
    output logic           sign_flag,
    output logic           zero_flag
);
    import cpu_pkg::*;

    logic       ir_load, addr_sel, mem_write, reg_write, ab_set;
    logic       alu_src, const_src, reg_data, reg_to_pc, reg_write_select;
    logic       pc_inc, pc_branch, pc_jump, operands_equal;
    logic [5:0] opcode;
    alu_fn_t    alu_control, alu_fn_field;
    imm_t       imm;
    word_t      rs_data, store_data, mem_rdata, mem_addr, npc;

    // pc addresses memory in fetch, the ALU result in the other phases.
    assign mem_addr = addr_sel ? alu_result : retire_pc;
    assign npc      = retire_pc + word_t'(1);

    control_fsm u_ctrl (
        .clk(clk), .rst(rst), .start(start), .opcode(opcode),
        .alu_fn_field(alu_fn_field), .operands_equal(operands_equal),
        .busy(busy), .halted(halted), .retire(retire), .ir_load(ir_load),
        .addr_sel(addr_sel), .mem_write(mem_write), .reg_write(reg_write),
        .ab_set(ab_set), .alu_src(alu_src), .const_src(const_src),
        .reg_data(reg_data), .reg_to_pc(reg_to_pc),
        .reg_write_select(reg_write_select), .alu_control(alu_control),
        .pc_inc(pc_inc), .pc_branch(pc_branch), .pc_jump(pc_jump)
    );

    pc_counter u_pc (
        .clk(clk), .rst(rst), .start(start), .pc_inc(pc_inc),
        .pc_branch(pc_branch), .pc_jump(pc_jump), .offset(imm),
        .target(rs_data), .pc(retire_pc)
    );

    main_memory u_mem (
        .clk(clk), .addr(mem_addr), .wdata(store_data), .we(mem_write),
        .rdata(mem_rdata), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data)
    );

    datapath u_dp (
        .clk(clk), .rst(rst), .mem_rdata(mem_rdata), .npc(npc),
        .ir_load(ir_load), .ab_set(ab_set), .reg_write(reg_write),
        .alu_src(alu_src), .const_src(const_src), .reg_data(reg_data),
        .reg_to_pc(reg_to_pc), .reg_write_select(reg_write_select),
        .alu_control(alu_control), .opcode(opcode), .alu_fn_field(alu_fn_field),
        .rs_data(rs_data), .store_data(store_data), .imm(imm),
        .operands_equal(operands_equal), .alu_result(alu_result),
        .carry_flag(carry_flag), .sign_flag(sign_flag), .zero_flag(zero_flag)
    );

endmodule

// ==== hdl/main_memory.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module main_memory (
    input  logic           clk,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    input  logic           we,
    output cpu_pkg::word_t rdata,
    input  logic           load_we,
    input  cpu_pkg::word_t load_addr,
    input  cpu_pkg::word_t load_data
);
    import cpu_pkg::*;

    localparam int AW = $clog2(`CPU_MEM_WORDS);

    word_t mem [`CPU_MEM_WORDS];

    // host writes only while the core is idle, so the ports never collide.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[AW-1:0]] <= wdata;
        end
        if (load_we) begin
            mem[load_addr[AW-1:0]] <= load_data;
        end
        rdata <= mem[addr[AW-1:0]];
    end

endmodule

// ==== hdl/pc_counter.sv ====
`timescale 1ns/1ps

module pc_counter (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           pc_inc,
    input  logic           pc_branch,
    input  logic           pc_jump,
    input  cpu_pkg::imm_t  offset,
    input  cpu_pkg::word_t target,
    output cpu_pkg::word_t pc
);
    import cpu_pkg::*;

    word_t pc_q;
    word_t offset_ext;

    assign offset_ext = {{($bits(word_t)-16){offset[15]}}, offset};

    always_ff @(posedge clk) begin
        if (rst || start) begin
            pc_q <= '0;
        end else if (pc_jump) begin
            pc_q <= target;
        end else if (pc_branch) begin
            // relative to the following instruction.
            pc_q <= pc_q + word_t'(1) + offset_ext;
        end else if (pc_inc) begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    assign pc = pc_q;

    assert property (@(posedge clk) disable iff (rst) $onehot0({pc_inc, pc_branch, pc_jump}))
        else $error("more than one pc update requested");

endmodule

// ==== control/control_fsm.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module control_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [5:0]       opcode,
    input  cpu_pkg::alu_fn_t alu_fn_field,
    input  logic             operands_equal,
    output logic             busy,
    output logic             halted,
    output logic             retire,
    output logic             ir_load,
    output logic             addr_sel,
    output logic             mem_write,
    output logic             reg_write,
    output logic             ab_set,
    output logic             alu_src,
    output logic             const_src,
    output logic             reg_data,
    output logic             reg_to_pc,
    output logic             reg_write_select,
    output cpu_pkg::alu_fn_t alu_control,
    output logic             pc_inc,
    output logic             pc_branch,
    output logic             pc_jump
);
    import cpu_pkg::*;

    cpu_state_e state_q, next_state;
    logic       in_wb;
    logic       writes_reg, writes_mem, is_branch, is_jal, is_jr, is_halt;
    logic       take_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    always_comb begin
        next_state = state_q;
        case (state_q)
            IDLE, HALTED: if (start) next_state = FETCH;
            FETCH:        next_state = DECODE;
            DECODE:       next_state = EXECUTE;
            EXECUTE:      next_state = WRITEBACK;
            WRITEBACK:    next_state = is_halt ? HALTED : FETCH;
            default:      next_state = IDLE;
        endcase
    end

    // decode; unknown opcodes fall through as a no-operation.
    always_comb begin
        alu_src          = 1'b0;
        const_src        = 1'b0;
        reg_data         = 1'b1;
        reg_to_pc        = 1'b0;
        reg_write_select = 1'b0;
        alu_control      = `CPU_FN_ADD;
        writes_reg       = 1'b0;
        writes_mem       = 1'b0;
        is_branch        = 1'b0;
        is_jal           = 1'b0;
        is_jr            = 1'b0;
        is_halt          = 1'b0;
        case (opcode)
            `CPU_OP_ALU: begin
                alu_control = alu_fn_field;
                writes_reg  = 1'b1;
            end
            `CPU_OP_ADDI: begin
                alu_src          = 1'b1;
                reg_write_select = 1'b1;
                writes_reg       = 1'b1;
            end
            `CPU_OP_SHI: begin
                alu_src          = 1'b1;
                const_src        = 1'b1;
                alu_control      = alu_fn_field;
                reg_write_select = 1'b1;
                writes_reg       = 1'b1;
            end
            `CPU_OP_LW: begin
                alu_src          = 1'b1;
                reg_data         = 1'b0;
                reg_write_select = 1'b1;
                writes_reg       = 1'b1;
            end
            `CPU_OP_SW: begin
                alu_src    = 1'b1;
                writes_mem = 1'b1;
            end
            `CPU_OP_BEQ: begin
                alu_control = `CPU_FN_SUB;
                is_branch   = 1'b1;
            end
            `CPU_OP_JAL: begin
                reg_to_pc  = 1'b1;
                writes_reg = 1'b1;
                is_jal     = 1'b1;
            end
            `CPU_OP_JR:   is_jr   = 1'b1;
            `CPU_OP_HALT: is_halt = 1'b1;
            default: ;
        endcase
    end

    assign in_wb       = (state_q == WRITEBACK);
    assign take_branch = is_jal || (is_branch && operands_equal);

    assign busy      = (state_q != IDLE) && (state_q != HALTED);
    assign halted    = (state_q == HALTED);
    assign retire    = in_wb;
    assign ir_load   = (state_q == DECODE);
    assign addr_sel  = (state_q != FETCH);
    assign ab_set    = in_wb;
    assign mem_write = writes_mem && (state_q == EXECUTE);
    assign reg_write = writes_reg && in_wb;
    assign pc_branch = take_branch && in_wb;
    assign pc_jump   = is_jr && in_wb;
    assign pc_inc    = in_wb && !take_branch && !is_jr;

    assert property (@(posedge clk) disable iff (rst) !(mem_write && reg_write))
        else $error("memory write and register write in the same cycle");

    // a retiring instruction was fetched from loaded memory.
    assert property (@(posedge clk) disable iff (rst) retire |-> !$isunknown(opcode))
        else $error("retired an instruction with an unknown opcode");

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module datapath (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::word_t    mem_rdata,
    input  cpu_pkg::word_t    npc,
    input  logic              ir_load,
    input  logic              ab_set,
    input  logic              reg_write,
    input  logic              alu_src,
    input  logic              const_src,
    input  logic              reg_data,
    input  logic              reg_to_pc,
    input  logic              reg_write_select,
    input  cpu_pkg::alu_fn_t  alu_control,
    output logic [5:0]        opcode,
    output cpu_pkg::alu_fn_t  alu_fn_field,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    store_data,
    output cpu_pkg::imm_t     imm,
    output logic              operands_equal,
    output cpu_pkg::word_t    alu_result,
    output logic              carry_flag,
    output logic              sign_flag,
    output logic              zero_flag
);
    import cpu_pkg::*;

    word_t    ir_q;
    word_t    rt_data;
    word_t    const_operand;
    word_t    alu_b;
    word_t    wb_data;
    word_t    alu_live;
    word_t    result_q;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t wb_idx;
    logic [4:0] shamt;
    logic     carry_live, sign_live, zero_live;
    logic     carry_q, sign_q, zero_q;

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir_q <= mem_rdata;
        end
    end

    assign opcode       = ir_q[31:26];
    assign rs_idx       = ir_q[25:21];
    assign rt_idx       = ir_q[20:16];
    assign shamt        = ir_q[15:11];
    assign alu_fn_field = ir_q[3:0];
    assign imm          = ir_q[15:0];

    // constant operand is the signed immediate or the zero-extended shift amount.
    assign const_operand = const_src ? {{(`CPU_XLEN-5){1'b0}}, shamt}
                                     : {{(`CPU_XLEN-16){imm[15]}}, imm};
    assign alu_b = alu_src ? const_operand : rt_data;

    // register ALU ops write back to rs, immediate and load forms to rt.
    assign wb_idx  = reg_to_pc ? reg_idx_t'(`CPU_LINK_REG)
                               : (reg_write_select ? rt_idx : rs_idx);
    assign wb_data = reg_to_pc ? npc : (reg_data ? alu_result : mem_rdata);

    register_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .we      (reg_write),
        .waddr   (wb_idx),
        .wdata   (wb_data),
        .raddr_a (rs_idx),
        .raddr_b (rt_idx),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

    alu u_alu (
        .a          (rs_data),
        .b          (alu_b),
        .fn         (alu_control),
        .result     (alu_live),
        .carry_flag (carry_live),
        .sign_flag  (sign_live),
        .zero_flag  (zero_live)
    );

    // result and flags track the ALU until ab_set freezes them.
    always_ff @(posedge clk) begin
        if (!ab_set) begin
            result_q <= alu_live;
            carry_q  <= carry_live;
            sign_q   <= sign_live;
            zero_q   <= zero_live;
        end
    end

    assign alu_result     = ab_set ? result_q : alu_live;
    assign carry_flag     = ab_set ? carry_q : carry_live;
    assign sign_flag      = ab_set ? sign_q : sign_live;
    assign zero_flag      = ab_set ? zero_q : zero_live;
    assign store_data     = rt_data;
    assign operands_equal = (rs_data == rt_data);

endmodule

// ==== datapath/register_file.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata,
    input  cpu_pkg::reg_idx_t raddr_a,
    input  cpu_pkg::reg_idx_t raddr_b,
    output cpu_pkg::word_t    rdata_a,
    output cpu_pkg::word_t    rdata_b
);
    import cpu_pkg::*;

    word_t regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, so its entry is never read back.
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_fn_t fn,
    output cpu_pkg::word_t   result,
    output logic             carry_flag,
    output logic             sign_flag,
    output logic             zero_flag
);
    import cpu_pkg::*;

    logic [`CPU_XLEN:0] sum_ext;
    logic [`CPU_XLEN:0] diff_ext;
    logic [4:0]         shamt;
    word_t              res;

    assign sum_ext  = {1'b0, a} + {1'b0, b};
    assign diff_ext = {1'b0, a} - {1'b0, b};
    assign shamt    = b[4:0];

    always_comb begin
        res        = '0;
        carry_flag = 1'b0;
        case (fn)
            `CPU_FN_ADD: begin
                res        = sum_ext[`CPU_XLEN-1:0];
                carry_flag = sum_ext[`CPU_XLEN];
            end
            `CPU_FN_SUB: begin
                // top bit of the widened difference is the borrow.
                res        = diff_ext[`CPU_XLEN-1:0];
                carry_flag = diff_ext[`CPU_XLEN];
            end
            `CPU_FN_AND: res = a & b;
            `CPU_FN_OR:  res = a | b;
            `CPU_FN_XOR: res = a ^ b;
            `CPU_FN_SLL: res = a << shamt;
            `CPU_FN_SRL: res = a >> shamt;
            `CPU_FN_SRA: res = word_t'($signed(a) >>> shamt);
            default:     res = '0;
        endcase
    end

    assign result    = res;
    assign sign_flag = res[`CPU_XLEN-1];
    assign zero_flag = (res == '0);

endmodule

// ==== common/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

    // data, address and instruction words share one width.
    typedef logic [`CPU_XLEN-1:0] word_t;

    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // immediate field, sign extended wherever it is used.
    typedef logic signed [15:0] imm_t;

    typedef logic [3:0] alu_fn_t;

    // one state per instruction phase, plus the two resting states.
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK,
        HALTED
    } cpu_state_e;

endpackage

// ==== common/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN      32
`define CPU_NREGS     32
`define CPU_MEM_WORDS 256
`define CPU_LINK_REG  31

// opcodes live in instruction bits 31:26.
`define CPU_OP_ALU  6'h00
`define CPU_OP_ADDI 6'h01
`define CPU_OP_SHI  6'h02
`define CPU_OP_LW   6'h03
`define CPU_OP_SW   6'h04
`define CPU_OP_BEQ  6'h05
`define CPU_OP_JAL  6'h06
`define CPU_OP_JR   6'h07
`define CPU_OP_HALT 6'h3f

// alu function codes, taken from instruction bits 3:0.
`define CPU_FN_ADD 4'h0
`define CPU_FN_SUB 4'h1
`define CPU_FN_AND 4'h2
`define CPU_FN_OR  4'h3
`define CPU_FN_XOR 4'h4
`define CPU_FN_SLL 4'h5
`define CPU_FN_SRL 4'h6
`define CPU_FN_SRA 4'h7

`endif
